//--- list.f
+incdir+design
design/axiCmdPkg.sv
design/cmdQueue.sv
design/axiCommandDivider.sv
design/arChannelDriver.sv
design/burstTracker.sv
design/axiReadCommandPath.sv
testbench/readPath_chk.sv
testbench/readPathMonitor.sv
testbench/tbReadCommandPath.sv

//--- build.sh
#!/bin/sh
# compile and run the read command path testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbReadCommandPath -f list.f -o simReadPath
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/simReadPath +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- testbench/tbReadCommandPath.sv
`timescale 1ns/1ns
`include "axiCmd_cfg.svh"

module tbReadCommandPath
    import axiCmdPkg::*;
();
    localparam int NumCmds = 10;

    // one column per field, one entry per command; the last column is its burst count.
    localparam addr_t CmdAddrs [NumCmds] = '{
        32'h0000_1000, 32'h0000_2000, 32'h0000_2400, 32'h0001_0000, 32'h0002_0040,
        32'h0003_0100, 32'h0004_0000, 32'h1000_0000, 32'h0005_0010, 32'h0006_0000
    };
    localparam cmdLen_t CmdLens [NumCmds] = '{
        16'd16, 16'd0, 16'd7, 16'd1, 16'd31, 16'd37, 16'd255, 16'd300, 16'd3, 16'd64
    };
    localparam int CmdBursts [NumCmds] = '{1, 0, 3, 1, 5, 4, 19, 20, 2, 4};

    logic      ACLK;
    logic      ARESETN;
    addr_t     cmdAddr;
    cmdLen_t   cmdLen;
    logic      cmdValid;
    logic      cmdReady;
    addr_t     arAddr;
    burstLen_t arLen;
    logic      arValid;
    logic      arReady;
    logic      rValid;
    logic      rLast;
    logic      cmdFlush;
    logic      runDone;
    int        seed;
    int        readyDraw;
    int        delayDraw;
    int        cycleCount;
    int        cycleLimit;
    int        expectedTotal;
    int        burstsSeen;
    int        checkCount;
    int        errorCount;
    int        dueCycles [$];

    axiReadCommandPath dut0 (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .cmdAddr  (cmdAddr),
        .cmdLen   (cmdLen),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .arAddr   (arAddr),
        .arLen    (arLen),
        .arValid  (arValid),
        .arReady  (arReady),
        .rValid   (rValid),
        .rLast    (rLast),
        .cmdFlush (cmdFlush)
    );

    readPathMonitor mon0 (
        .ACLK          (ACLK),
        .ARESETN       (ARESETN),
        .cmdAddr       (cmdAddr),
        .cmdLen        (cmdLen),
        .cmdValid      (cmdValid),
        .cmdReady      (cmdReady),
        .arAddr        (arAddr),
        .arLen         (arLen),
        .arValid       (arValid),
        .arReady       (arReady),
        .cmdFlush      (cmdFlush),
        .runDone       (runDone),
        .expectedTotal (expectedTotal),
        .burstsSeen    (burstsSeen),
        .checkCount    (checkCount),
        .errorCount    (errorCount)
    );

    bind axiReadCommandPath readPathChk chk0 (
        .ACLK    (ACLK),
        .ARESETN (ARESETN),
        .arAddr  (arAddr),
        .arLen   (arLen),
        .arValid (arValid),
        .arReady (arReady),
        .rValid  (rValid),
        .rLast   (rLast)
    );

    initial
        ACLK = 1'b0;

    always #10 ACLK = ~ACLK;

    task automatic sendCommand(input addr_t addr, input cmdLen_t len);
        cmdAddr = addr;
        cmdLen = len;
        cmdValid = 1'b1;
        // cmdReady only moves on a rising edge, so it is stable here.
        while (!cmdReady)
            @(negedge ACLK);
        @(negedge ACLK);
        cmdValid = 1'b0;
    endtask

    // AXI slave side with random arReady and delayed last beats, plus the cycle limit.
    always @(negedge ACLK)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout: run still busy after %0d cycles", cycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
        else
        begin
            readyDraw = $random(seed);
            arReady = readyDraw[0];
            if (dueCycles.size() != 0 && dueCycles[0] <= cycleCount)
            begin
                rValid = 1'b1;
                rLast = 1'b1;
                void'(dueCycles.pop_front());
            end
            else
            begin
                rValid = 1'b0;
                rLast = 1'b0;
            end
        end
    end

    always @(posedge ACLK)
    begin
        if (ARESETN && arValid && arReady)
        begin
            delayDraw = $random(seed);
            dueCycles.push_back(cycleCount + int'($unsigned(delayDraw) % 7));
        end
    end

    initial
    begin
        ARESETN = 1'b0;
        cmdAddr = '0;
        cmdLen = '0;
        cmdValid = 1'b0;
        arReady = 1'b0;
        rValid = 1'b0;
        rLast = 1'b0;
        runDone = 1'b0;
        seed = 32'h0569_e5fd;
        cycleCount = 0;
        expectedTotal = 0;
        cycleLimit = 16;
        for (int i = 0; i < NumCmds; i++)
        begin
            expectedTotal += CmdBursts[i];
            cycleLimit += CmdBursts[i] * 12 + 20;
        end

        repeat (16) @(posedge ACLK);
        @(negedge ACLK);
        ARESETN = 1'b1;

        for (int i = 0; i < NumCmds; i++)
            sendCommand(CmdAddrs[i], CmdLens[i]);

        // drain until every burst is issued and its last beat returned.
        while (burstsSeen < expectedTotal || dueCycles.size() != 0 || rValid)
            @(negedge ACLK);
        repeat (4) @(negedge ACLK);
        runDone = 1'b1;
        repeat (2) @(negedge ACLK);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checkCount, errorCount, dut0.chk0.failures);
        if (errorCount == 0 && dut0.chk0.failures == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/readPathMonitor.sv
`timescale 1ns/1ns
`include "axiCmd_cfg.svh"

module readPathMonitor
    import axiCmdPkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETN,
    input  addr_t     cmdAddr,
    input  cmdLen_t   cmdLen,
    input  logic      cmdValid,
    input  logic      cmdReady,
    input  addr_t     arAddr,
    input  burstLen_t arLen,
    input  logic      arValid,
    input  logic      arReady,
    input  logic      cmdFlush,
    input  logic      runDone,
    input  int        expectedTotal,
    output int        burstsSeen,
    output int        checkCount,
    output int        errorCount
);
    addr_t     expAddr [$];
    burstLen_t expLen [$];
    addr_t     nextAddr;
    burstLen_t nextLen;
    int        resetCycles;
    logic      finalDone;

    initial
    begin
        burstsSeen = 0;
        checkCount = 0;
        errorCount = 0;
        resetCycles = 0;
        finalDone = 1'b0;
    end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, got);
        end
    endtask

    // full-size bursts while they fit, then halve the size until the rest is used up.
    task automatic expandCommand(input addr_t startAddr, input cmdLen_t len);
        int    remaining;
        int    size;
        addr_t addr;
        remaining = int'(len);
        size = `MAX_BURST;
        addr = startAddr;
        while (remaining > 0)
        begin
            if (remaining >= size)
            begin
                expAddr.push_back(addr);
                expLen.push_back(burstLen_t'(size - 1));
                addr = addr + addr_t'(size * (`AXI_DATA_WIDTH / 8));
                remaining = remaining - size;
            end
            else
                size = size / 2;
        end
    endtask

    always @(posedge ACLK)
    begin
        if (!ARESETN)
        begin
            resetCycles++;
            if (resetCycles == 8)
            begin
                compareValue("arValid", 32'(arValid), 32'd0);
                compareValue("cmdReady", 32'(cmdReady), 32'd1);
                compareValue("cmdFlush", 32'(cmdFlush), 32'd1);
            end
        end
        else
        begin
            if (cmdValid && cmdReady)
                expandCommand(cmdAddr, cmdLen);
            if (arValid && arReady)
            begin
                burstsSeen++;
                if (expAddr.size() == 0)
                begin
                    errorCount++;
                    $display("%0t: burst at %h was issued with no command left for it",
                             $time, arAddr);
                end
                else
                begin
                    nextAddr = expAddr.pop_front();
                    nextLen = expLen.pop_front();
                    compareValue("arAddr", arAddr, nextAddr);
                    compareValue("arLen", 32'(arLen), 32'(nextLen));
                end
            end
            if (runDone && !finalDone)
            begin
                finalDone = 1'b1;
                compareValue("cmdFlush", 32'(cmdFlush), 32'd1);
                compareValue("burst count", 32'(burstsSeen), 32'(expectedTotal));
                if (expAddr.size() != 0)
                begin
                    errorCount++;
                    $display("%0d expected bursts were never issued", expAddr.size());
                end
            end
        end
    end

endmodule

//--- testbench/readPath_chk.sv
`timescale 1ns/1ns
`include "axiCmd_cfg.svh"

module readPathChk
    import axiCmdPkg::*;
(
    input logic      ACLK,
    input logic      ARESETN,
    input addr_t     arAddr,
    input burstLen_t arLen,
    input logic      arValid,
    input logic      arReady,
    input logic      rValid,
    input logic      rLast
);
    int inFlight;
    int failures;

    initial
    begin
        failures = 0;
    end

    // bursts accepted on AR and not yet closed by a last beat.
    always @(posedge ACLK)
    begin
        if (!ARESETN)
            inFlight <= 0;
        else if (arValid && arReady && !(rValid && rLast))
            inFlight <= inFlight + 1;
        else if (!(arValid && arReady) && rValid && rLast)
            inFlight <= inFlight - 1;
    end

    holdWhileStalled: assert property (@(posedge ACLK) disable iff (!ARESETN)
        arValid && !arReady |=> arValid && $stable(arAddr) && $stable(arLen))
    else
    begin
        $error("AR burst changed or dropped before arReady");
        failures = failures + 1;
    end

    // arLen + 1 must be a power of two within the maximum burst.
    legalLength: assert property (@(posedge ACLK) disable iff (!ARESETN)
        arValid |-> ((arLen & (arLen + 8'd1)) == 8'd0) && (int'(arLen) < `MAX_BURST))
    else
    begin
        $error("arLen %0d is not a legal burst length", arLen);
        failures = failures + 1;
    end

    outstandingLimit: assert property (@(posedge ACLK) disable iff (!ARESETN)
        inFlight <= `MAX_OUTSTANDING)
    else
    begin
        $error("%0d bursts in flight, above the limit", inFlight);
        failures = failures + 1;
    end

endmodule

//--- design/axiReadCommandPath.sv
`timescale 1ns/1ns

module axiReadCommandPath
    import axiCmdPkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETN,
    input  addr_t     cmdAddr,
    input  cmdLen_t   cmdLen,
    input  logic      cmdValid,
    output logic      cmdReady,
    output addr_t     arAddr,
    output burstLen_t arLen,
    output logic      arValid,
    input  logic      arReady,
    input  logic      rValid,
    input  logic      rLast,
    output logic      cmdFlush
);
    addr_t     srcAddr;
    cmdLen_t   srcLen;
    logic      srcValid;
    logic      srcReady;
    logic      issuePermit;
    addr_t     divAddr;
    burstLen_t divLen;
    logic      divValid;
    logic      divReady;

    cmdQueue queue0 (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .cmdAddr  (cmdAddr),
        .cmdLen   (cmdLen),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .srcAddr  (srcAddr),
        .srcLen   (srcLen),
        .srcValid (srcValid),
        .srcReady (srcReady)
    );

    axiCommandDivider divider0 (
        .ACLK        (ACLK),
        .ARESETN     (ARESETN),
        .srcAddr     (srcAddr),
        .srcLen      (srcLen),
        .srcValid    (srcValid),
        .srcReady    (srcReady),
        .issuePermit (issuePermit),
        .divAddr     (divAddr),
        .divLen      (divLen),
        .divValid    (divValid),
        .divReady    (divReady),
        .divFlush    (cmdFlush)
    );

    arChannelDriver driver0 (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .divAddr  (divAddr),
        .divLen   (divLen),
        .divValid (divValid),
        .divReady (divReady),
        .arAddr   (arAddr),
        .arLen    (arLen),
        .arValid  (arValid),
        .arReady  (arReady)
    );

    burstTracker tracker0 (
        .ACLK        (ACLK),
        .ARESETN     (ARESETN),
        .arValid     (arValid),
        .arReady     (arReady),
        .rValid      (rValid),
        .rLast       (rLast),
        .issuePermit (issuePermit)
    );

endmodule

//--- design/burstTracker.sv
`timescale 1ns/1ns
`include "axiCmd_cfg.svh"

module burstTracker
(
    input  logic ACLK,
    input  logic ARESETN,
    input  logic arValid,
    input  logic arReady,
    input  logic rValid,
    input  logic rLast,
    output logic issuePermit
);
    localparam int CountWidth = $clog2(`MAX_OUTSTANDING + 1);
    localparam logic [CountWidth-1:0] PermitLimit = CountWidth'(`MAX_OUTSTANDING - 1);

    logic [CountWidth-1:0] outstanding;
    logic                  opened;
    logic                  closed;

    assign opened = arValid && arReady;
    assign closed = rValid && rLast;

    // one slot is kept back for the burst in the divider, one for the driver.
    assign issuePermit = (outstanding < PermitLimit);

    always_ff @(posedge ACLK)
    begin
        if (!ARESETN)
        begin
            outstanding <= '0;
        end
        else
        begin
            case ({opened, closed})
                2'b10:
                    outstanding <= outstanding + 1'b1;
                2'b01:
                    outstanding <= outstanding - 1'b1;
                default:
                    outstanding <= outstanding;
            endcase
        end
    end

endmodule

//--- design/arChannelDriver.sv
`timescale 1ns/1ns

module arChannelDriver
    import axiCmdPkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETN,
    input  addr_t     divAddr,
    input  burstLen_t divLen,
    input  logic      divValid,
    output logic      divReady,
    output addr_t     arAddr,
    output burstLen_t arLen,
    output logic      arValid,
    input  logic      arReady
);
    logic load;

    // the register can take a new burst when empty or draining this cycle.
    assign divReady = !arValid || arReady;
    assign load = divValid && divReady;

    always_ff @(posedge ACLK)
    begin
        if (!ARESETN)
        begin
            arValid <= 1'b0;
        end
        else
        begin
            if (divReady)
                arValid <= divValid;
        end
    end

    // fields only change on a load, so they hold while arReady is low.
    always_ff @(posedge ACLK)
    begin
        if (load)
        begin
            arAddr <= divAddr;
            arLen <= divLen;
        end
    end

endmodule

//--- design/axiCommandDivider.sv
`timescale 1ns/1ns
`include "axiCmd_cfg.svh"

module axiCommandDivider
    import axiCmdPkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETN,
    input  addr_t     srcAddr,
    input  cmdLen_t   srcLen,
    input  logic      srcValid,
    output logic      srcReady,
    input  logic      issuePermit,
    output addr_t     divAddr,
    output burstLen_t divLen,
    output logic      divValid,
    input  logic      divReady,
    output logic      divFlush
);
    localparam int SizeWidth = $clog2(`MAX_BURST) + 1;
    localparam int ByteShift = $clog2(`AXI_DATA_WIDTH / 8);

    divState_t            state;
    addr_t                curAddr;
    cmdLen_t              remaining;
    logic [SizeWidth-1:0] burstSize;
    logic                 srcTake;
    logic                 fits;
    logic                 emit;
    logic                 divTake;

    assign srcReady = (state == stateIdle) && issuePermit;
    assign srcTake = srcValid && srcReady;
    assign fits = (remaining >= cmdLen_t'(burstSize));
    // a burst only leaves while the tracker still has room for it.
    assign emit = (state == stateDividing) && fits && issuePermit;
    assign divTake = divValid && divReady;

    assign divAddr = curAddr;
    assign divFlush = (state == stateIdle) || ((state == stateRequest) && !divReady);

    always_ff @(posedge ACLK)
    begin
        if (!ARESETN)
        begin
            state <= stateIdle;
            divValid <= 1'b0;
        end
        else
        begin
            case (state)
                stateIdle:
                    // zero-length commands are popped and dropped here.
                    if (srcTake && (srcLen != '0))
                        state <= stateDividing;
                stateDividing:
                    if (emit)
                    begin
                        state <= stateRequest;
                        divValid <= 1'b1;
                    end
                stateRequest:
                    if (divTake)
                    begin
                        state <= (remaining == '0) ? stateIdle : stateDividing;
                        divValid <= 1'b0;
                    end
                default:
                    state <= stateIdle;
            endcase
        end
    end

    always_ff @(posedge ACLK)
    begin
        case (state)
            stateIdle:
            begin
                burstSize <= SizeWidth'(`MAX_BURST);
                if (srcTake)
                begin
                    curAddr <= srcAddr;
                    remaining <= srcLen;
                end
            end
            stateDividing:
                if (emit)
                begin
                    remaining <= remaining - cmdLen_t'(burstSize);
                    divLen <= burstLen_t'(burstSize - 1'b1);
                end
                else if (!fits)
                    burstSize <= burstSize >> 1;
            stateRequest:
                // next burst starts right after this one in bytes.
                if (divTake)
                    curAddr <= curAddr + (addr_t'(burstSize) << ByteShift);
            default:
                burstSize <= SizeWidth'(`MAX_BURST);
        endcase
    end

endmodule

//--- design/cmdQueue.sv
`timescale 1ns/1ns
`include "axiCmd_cfg.svh"

module cmdQueue
    import axiCmdPkg::*;
(
    input  logic    ACLK,
    input  logic    ARESETN,
    input  addr_t   cmdAddr,
    input  cmdLen_t cmdLen,
    input  logic    cmdValid,
    output logic    cmdReady,
    output addr_t   srcAddr,
    output cmdLen_t srcLen,
    output logic    srcValid,
    input  logic    srcReady
);
    localparam int PtrWidth = $clog2(`CMD_QUEUE_DEPTH);

    addr_t             addrMem [`CMD_QUEUE_DEPTH];
    cmdLen_t           lenMem [`CMD_QUEUE_DEPTH];
    logic [PtrWidth:0] wrPtr;
    logic [PtrWidth:0] rdPtr;
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;

    // the extra pointer bit tells a full queue from an empty one.
    assign empty = (wrPtr == rdPtr);
    assign full = (wrPtr[PtrWidth] != rdPtr[PtrWidth]) &&
                  (wrPtr[PtrWidth-1:0] == rdPtr[PtrWidth-1:0]);

    assign cmdReady = !full;
    assign srcValid = !empty;
    assign push = cmdValid && cmdReady;
    assign pop = srcValid && srcReady;

    assign srcAddr = addrMem[rdPtr[PtrWidth-1:0]];
    assign srcLen = lenMem[rdPtr[PtrWidth-1:0]];

    always_ff @(posedge ACLK)
    begin
        if (push)
        begin
            addrMem[wrPtr[PtrWidth-1:0]] <= cmdAddr;
            lenMem[wrPtr[PtrWidth-1:0]] <= cmdLen;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (!ARESETN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
        end
    end

endmodule

//--- design/axiCmdPkg.sv
`include "axiCmd_cfg.svh"

package axiCmdPkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

    typedef logic [`CMD_LEN_WIDTH-1:0] cmdLen_t;

    // AXI burst length, beats minus one.
    typedef logic [7:0] burstLen_t;

    typedef enum logic [1:0]
    {
        stateIdle,
        stateDividing,
        stateRequest
    } divState_t;

endpackage

//--- design/axiCmd_cfg.svh
`ifndef AXI_CMD_CFG_SVH
`define AXI_CMD_CFG_SVH

// address and data bus widths in bits.
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32

// command length in data beats.
`define CMD_LEN_WIDTH 16

// largest burst in beats, a power of two up to 256.
`define MAX_BURST 16

`define MAX_OUTSTANDING 4
`define CMD_QUEUE_DEPTH 4
`endif
